/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := i3c_ctrl_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
design/i3c_ctrl_pkg.sv
design/pp_period_lut.sv
design/phase_timer.sv
design/byte_shifter.sv
design/bus_sequencer.sv
design/i3c_ctrl_top.sv
test/i3c_ctrl_tb.sv

/* design/bus_sequencer.sv */
module bus_sequencer
  import i3c_ctrl_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              enable_i,
  input  logic              cmd_valid_i,  // Single-cycle strobe
  input  cmd_req_t          cmd_i,
  input  logic              expired_i,    // Timer at last cycle
  input  logic              bit_i,        // TX bit from shifter
  input  logic              last_bit_i,
  output logic              load_o,       // Timer load
  output phase_e            phase_o,
  output logic              byte_load_o,
  output logic [DATA_W-1:0] byte_data_o,
  output logic              shift_in_o,
  output logic              advance_o,
  output bus_lines_t        lines_o,
  output logic              idle_o,
  output logic              cmd_done_o,
  output logic              rx_valid_o
);

  typedef enum logic [3:0] {
    Idle,        // Lines released
    SetupStart,  // Both high before START
    HoldStart,   // SDA low under high SCL
    ClockStart,  // SCL pulled low
    ClockLow,    // Data bit driven
    ClockPulse,  // SCL high, target samples
    HoldBit,     // SCL low, data held
    SetupStop,   // SCL high, SDA low
    HoldStop     // Both high, bus free
  } state_e;

  state_e state_q, state_d;
  logic   is_tx_q;   // Direction of current byte
  logic   accept;
  logic   step;      // Current phase ends this cycle
  logic   sda_data;  // SDA during a bit

  assign idle_o = (state_q == Idle);
  assign accept = idle_o && enable_i && cmd_valid_i;  // Dropped otherwise
  assign step   = expired_i && enable_i;              // Frozen with enable low

  // Zero load for RX, since bits get shifted in
  assign byte_data_o = (cmd_i.cmd == cmd_tx) ? cmd_i.data : '0;

  // ==============================
  // Next state and strobes
  // ==============================
  always_comb begin : next_state
    state_d     = state_q;
    load_o      = 1'b0;
    phase_o     = ph_no_delay;
    byte_load_o = 1'b0;
    shift_in_o  = 1'b0;
    advance_o   = 1'b0;
    cmd_done_o  = 1'b0;
    rx_valid_o  = 1'b0;

    unique case (state_q)
      Idle: begin
        if (accept) begin
          load_o = 1'b1;
          unique case (cmd_i.cmd)
            cmd_start: begin
              state_d = SetupStart;
              phase_o = ph_setup_start;
            end
            cmd_stop: begin
              state_d = SetupStop;
              phase_o = ph_setup_stop;
            end
            default: begin  // TX or RX byte
              state_d     = ClockLow;
              phase_o     = ph_clock_low;
              byte_load_o = 1'b1;
            end
          endcase
        end
      end
      SetupStart: if (step) begin
        state_d = HoldStart;
        load_o  = 1'b1;
        phase_o = ph_hold_start;
      end
      HoldStart: if (step) begin
        state_d = ClockStart;
        load_o  = 1'b1;
        phase_o = ph_no_delay;  // One cycle with both low
      end
      ClockStart: if (step) begin
        state_d    = Idle;
        load_o     = 1'b1;
        cmd_done_o = 1'b1;      // START finished
      end
      ClockLow: if (step) begin
        state_d = ClockPulse;
        load_o  = 1'b1;
        phase_o = ph_clock_pulse;
      end
      ClockPulse: if (step) begin
        state_d    = HoldBit;
        load_o     = 1'b1;
        phase_o    = ph_hold_bit;
        shift_in_o = !is_tx_q;  // Sample at end of high phase
      end
      HoldBit: if (step) begin
        load_o = 1'b1;
        if (last_bit_i) begin
          state_d    = Idle;
          cmd_done_o = 1'b1;
          rx_valid_o = !is_tx_q;  // Full byte in shifter now
        end else begin
          state_d   = ClockLow;
          phase_o   = ph_clock_low;
          advance_o = 1'b1;
        end
      end
      SetupStop: if (step) begin
        state_d = HoldStop;
        load_o  = 1'b1;
        phase_o = ph_hold_stop;
      end
      HoldStop: if (step) begin
        state_d    = Idle;
        load_o     = 1'b1;
        cmd_done_o = 1'b1;      // Bus free time over
      end
      default: state_d = Idle;
    endcase
  end

  // ==============================
  // Line values
  // ==============================
  assign sda_data = is_tx_q ? bit_i : 1'b1;  // Released for RX

  always_comb begin : line_values
    unique case (state_q)
      HoldStart:  lines_o = '{scl: 1'b1, sda: 1'b0};
      ClockStart: lines_o = '{scl: 1'b0, sda: 1'b0};
      ClockLow,
      HoldBit:    lines_o = '{scl: 1'b0, sda: sda_data};
      ClockPulse: lines_o = '{scl: 1'b1, sda: sda_data};
      SetupStop:  lines_o = '{scl: 1'b1, sda: 1'b0};
      default:    lines_o = '{scl: 1'b1, sda: 1'b1};  // Idle, SetupStart, HoldStop
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= Idle;
      is_tx_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept && (cmd_i.cmd == cmd_tx || cmd_i.cmd == cmd_rx)) begin
        is_tx_q <= (cmd_i.cmd == cmd_tx);
      end
    end
  end

endmodule

/* design/byte_shifter.sv */
module byte_shifter
  import i3c_ctrl_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              load_i,      // New byte, index back to MSB
  input  logic [DATA_W-1:0] data_i,      // TX byte, zero for RX
  input  logic              shift_in_i,  // Take sda_i at LSB end
  input  logic              advance_i,   // Next bit
  input  logic              sda_i,
  output logic              bit_o,       // Current TX bit
  output logic              last_bit_o,
  output logic [DATA_W-1:0] data_o
);

  logic [DATA_W-1:0]    shift_q;
  logic [BIT_IDX_W-1:0] idx_q;

  // ==============================
  // Bit index
  // ==============================
  always_ff @(posedge clk_i or negedge rst_ni) begin : bit_index
    if (!rst_ni) begin
      idx_q <= BIT_IDX_W'(DATA_W - 1);
    end else if (load_i) begin
      idx_q <= BIT_IDX_W'(DATA_W - 1);  // MSB first
    end else if (advance_i) begin
      idx_q <= idx_q - 1'b1;
    end
  end

  // ==============================
  // Data register
  // ==============================
  // TX keeps the byte still and indexes it, RX shifts toward the MSB
  always_ff @(posedge clk_i) begin : shift_reg
    if (load_i) begin
      shift_q <= data_i;
    end else if (shift_in_i) begin
      shift_q <= {shift_q[DATA_W-2:0], sda_i};
    end
  end

  assign bit_o      = shift_q[idx_q];
  assign last_bit_o = (idx_q == '0);  // Bit 0 in flight
  assign data_o     = shift_q;

endmodule

/* design/i3c_ctrl_pkg.sv */
package i3c_ctrl_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int unsigned TIME_W    = 20;  // Timing values and phase counter
  localparam int unsigned DATA_W    = 8;   // One bus byte
  localparam int unsigned HALF_W    = 8;   // Push-pull half period
  localparam int unsigned BIT_IDX_W = 3;   // Bit index within a byte
  localparam int unsigned CLK_MHZ_W = 16;  // System clock in MHz

  // SDR speed, sdr0 fastest
  typedef enum logic [2:0] {
    sdr0 = 3'd0,
    sdr1 = 3'd1,
    sdr2 = 3'd2,
    sdr3 = 3'd3,
    sdr4 = 3'd4
  } sdr_mode_e;

  // Bus commands
  typedef enum logic [1:0] {
    cmd_start = 2'd0,
    cmd_stop  = 2'd1,
    cmd_tx    = 2'd2,
    cmd_rx    = 2'd3
  } bus_cmd_e;

  // Strobe payload
  typedef struct packed {
    bus_cmd_e              cmd;
    logic [DATA_W-1:0]     data;  // Only for cmd_tx
  } cmd_req_t;

  // ==============================
  // Timing configuration
  // ==============================
  // Open-drain timings, all in system clock cycles
  typedef struct packed {
    logic [TIME_W-1:0] t_r;      // Rise time
    logic [TIME_W-1:0] t_f;      // Fall time
    logic [TIME_W-1:0] thigh;    // SCL high
    logic [TIME_W-1:0] tlow;     // SCL low
    logic [TIME_W-1:0] thd_sta;  // START hold
    logic [TIME_W-1:0] tsu_sta;  // START setup
    logic [TIME_W-1:0] tsu_sto;  // STOP setup
    logic [TIME_W-1:0] tsu_dat;  // Data setup
    logic [TIME_W-1:0] thd_dat;  // Data hold
    logic [TIME_W-1:0] t_buf;    // Bus free
  } od_timing_t;

  typedef struct packed {
    logic [CLK_MHZ_W-1:0] sys_clk_mhz;  // 100, 200 or 400
    sdr_mode_e            sdr;
  } pp_cfg_t;

  // Timed phases the sequencer can load
  typedef enum logic [3:0] {
    ph_setup_start,
    ph_hold_start,
    ph_setup_data,
    ph_clock_low,
    ph_clock_pulse,
    ph_hold_bit,
    ph_setup_stop,
    ph_hold_stop,
    ph_no_delay
  } phase_e;

  typedef struct packed {
    logic scl;
    logic sda;
  } bus_lines_t;

endpackage

/* design/i3c_ctrl_top.sv */
module i3c_ctrl_top
  import i3c_ctrl_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              enable_i,      // Host enable gate
  input  logic              od_pp_mode_i,  // 0 open-drain, 1 push-pull
  input  od_timing_t        od_timing_i,
  input  pp_cfg_t           pp_cfg_i,
  input  logic              cmd_valid_i,
  input  cmd_req_t          cmd_i,
  input  logic              sda_i,         // Sampled bus data
  output bus_lines_t        lines_o,
  output logic              idle_o,
  output logic              cmd_done_o,
  output logic              rx_valid_o,
  output logic [DATA_W-1:0] rx_data_o
);

  // Sequencer to timer
  logic              tmr_load;
  phase_e            tmr_phase;
  logic              tmr_expired;
  // Sequencer to shifter
  logic              byte_load;
  logic [DATA_W-1:0] byte_data;
  logic              shift_in;
  logic              advance;
  logic              tx_bit;
  logic              last_bit;

  bus_sequencer u_bus_sequencer (
    .clk_i, .rst_ni, .enable_i, .cmd_valid_i, .cmd_i,
    .expired_i   (tmr_expired),
    .bit_i       (tx_bit),
    .last_bit_i  (last_bit),
    .load_o      (tmr_load),
    .phase_o     (tmr_phase),
    .byte_load_o (byte_load),
    .byte_data_o (byte_data),
    .shift_in_o  (shift_in),
    .advance_o   (advance),
    .lines_o, .idle_o, .cmd_done_o, .rx_valid_o
  );

  phase_timer u_phase_timer (
    .clk_i, .rst_ni, .enable_i, .od_pp_mode_i, .od_timing_i, .pp_cfg_i,
    .load_i    (tmr_load),
    .phase_i   (tmr_phase),
    .expired_o (tmr_expired)
  );

  byte_shifter u_byte_shifter (
    .clk_i, .rst_ni, .sda_i,
    .load_i     (byte_load),
    .data_i     (byte_data),
    .shift_in_i (shift_in),
    .advance_i  (advance),
    .bit_o      (tx_bit),
    .last_bit_o (last_bit),
    .data_o     (rx_data_o)  // RX byte valid with rx_valid_o
  );

endmodule

/* design/phase_timer.sv */
module phase_timer
  import i3c_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       enable_i,      // Freezes count when low
  input  logic       od_pp_mode_i,  // 0 open-drain, 1 push-pull
  input  od_timing_t od_timing_i,
  input  pp_cfg_t    pp_cfg_i,
  input  logic       load_i,
  input  phase_e     phase_i,
  output logic       expired_o      // Last cycle of phase
);

  logic [HALF_W-1:0]        half_period;
  logic signed [TIME_W+1:0] od_len;    // Two spare bits for sums and differences
  logic signed [TIME_W+1:0] pp_len;
  logic signed [TIME_W+1:0] raw_len;
  logic [TIME_W-1:0]        load_len;  // Clamped
  logic [TIME_W-1:0]        count_q;

  // Zero-extend a timing field to the wide signed range
  function automatic logic signed [TIME_W+1:0] ext(input logic [TIME_W-1:0] val);
    ext = {2'b00, val};
  endfunction

  pp_period_lut u_pp_period_lut (
    .pp_cfg_i      (pp_cfg_i),
    .half_period_o (half_period)
  );

  // ==============================
  // Phase length
  // ==============================
  always_comb begin : od_length
    unique case (phase_i)
      ph_setup_start: od_len = ext(od_timing_i.t_r) + ext(od_timing_i.tsu_sta);
      ph_hold_start:  od_len = ext(od_timing_i.t_f) + ext(od_timing_i.thd_sta);
      ph_setup_data:  od_len = ext(od_timing_i.t_r) + ext(od_timing_i.tsu_dat);
      ph_clock_low:   od_len = ext(od_timing_i.tlow) - ext(od_timing_i.thd_dat);
      ph_clock_pulse: od_len = ext(od_timing_i.t_r) + ext(od_timing_i.thigh);
      ph_hold_bit:    od_len = ext(od_timing_i.t_f) + ext(od_timing_i.thd_dat);
      ph_setup_stop:  od_len = ext(od_timing_i.t_r) + ext(od_timing_i.tsu_sto);
      ph_hold_stop:   od_len = ext(od_timing_i.t_r) + ext(od_timing_i.t_buf)
                             - ext(od_timing_i.tsu_sta);
      default:        od_len = 'sd1;  // ph_no_delay
    endcase
  end

  // Push-pull, 50% duty clock and single-cycle edges
  assign pp_len = (phase_i == ph_clock_low || phase_i == ph_clock_pulse) ?
                  {{(TIME_W+2-HALF_W){1'b0}}, half_period} : 'sd1;

  assign raw_len = od_pp_mode_i ? pp_len : od_len;

  always_comb begin : clamp_length
    if (raw_len < 1) begin
      load_len = TIME_W'(1);                 // Negative or zero length
    end else if (raw_len[TIME_W+1:TIME_W] != 2'b00) begin
      load_len = '1;                         // Saturate
    end else begin
      load_len = raw_len[TIME_W-1:0];
    end
  end

  // ==============================
  // Down counter
  // ==============================
  always_ff @(posedge clk_i or negedge rst_ni) begin : counter
    if (!rst_ni) begin
      count_q <= TIME_W'(1);
    end else if (load_i) begin
      count_q <= load_len;
    end else if (enable_i && (count_q > TIME_W'(1))) begin
      count_q <= count_q - 1'b1;  // Stops at 1
    end
  end

  assign expired_o = (count_q == TIME_W'(1));

endmodule

/* design/pp_period_lut.sv */
module pp_period_lut
  import i3c_ctrl_pkg::*;
(
  input  pp_cfg_t             pp_cfg_i,
  output logic [HALF_W-1:0]   half_period_o  // SCL half period in clk_i cycles
);

  // Rounded up so SCL never runs faster than the SDR limit
  always_comb begin : lut
    unique case (pp_cfg_i.sys_clk_mhz)
      CLK_MHZ_W'(200): begin
        unique case (pp_cfg_i.sdr)
          sdr0:    half_period_o = 8'd8;    // 12.5 MHz
          sdr1:    half_period_o = 8'd13;
          sdr2:    half_period_o = 8'd17;
          sdr3:    half_period_o = 8'd25;   // 4 MHz
          sdr4:    half_period_o = 8'd50;   // 2 MHz
          default: half_period_o = 8'd50;   // Slowest
        endcase
      end
      CLK_MHZ_W'(400): begin
        unique case (pp_cfg_i.sdr)
          sdr0:    half_period_o = 8'd16;   // 12.5 MHz
          sdr1:    half_period_o = 8'd25;   // 8 MHz
          sdr2:    half_period_o = 8'd34;
          sdr3:    half_period_o = 8'd50;   // 4 MHz
          sdr4:    half_period_o = 8'd100;  // 2 MHz
          default: half_period_o = 8'd100;  // Slowest
        endcase
      end
      default: begin
        // 100 MHz, also the fallback for any other clock
        unique case (pp_cfg_i.sdr)
          sdr0:    half_period_o = 8'd4;    // 12.5 MHz
          sdr1:    half_period_o = 8'd7;
          sdr2:    half_period_o = 8'd9;
          sdr3:    half_period_o = 8'd13;
          sdr4:    half_period_o = 8'd25;   // 2 MHz
          default: half_period_o = 8'd25;   // Slowest
        endcase
      end
    endcase
  end

endmodule

/* test/i3c_ctrl_tb.sv */
module i3c_ctrl_tb
  import i3c_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // One table row per command
  typedef struct packed {
    logic              pp;        // Push-pull mode
    logic              en;        // Host enable while strobing
    logic              poke;      // Second strobe while busy
    od_timing_t        od;
    pp_cfg_t           ppc;
    bus_cmd_e          cmd;
    logic [DATA_W-1:0] data;      // TX byte, or byte the target returns
    logic [TIME_W-1:0] exp_high;  // SCL high time, push-pull half period too
  } test_entry_t;

  // Running event counts from the bus monitor
  typedef struct packed {
    logic [TIME_W-1:0] busy;     // Cycles with idle_o low
    logic [TIME_W-1:0] done;
    logic [TIME_W-1:0] rx;
    logic [TIME_W-1:0] start;    // SDA fall under high SCL
    logic [TIME_W-1:0] stop;     // SDA rise under high SCL
    logic [TIME_W-1:0] rise;     // SCL rising edges while busy
    logic [TIME_W-1:0] sda_low;
  } counts_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              enable;
  logic              od_pp_mode;
  od_timing_t        od_timing;
  pp_cfg_t           pp_cfg;
  logic              cmd_valid;
  cmd_req_t          cmd_req;
  logic              sda = 1'b1;  // Target model output
  bus_lines_t        lines;
  logic              idle;
  logic              cmd_done;
  logic              rx_valid;
  logic [DATA_W-1:0] rx_data;

  test_entry_t       tests[$];
  counts_t           cnt = '0;
  bus_lines_t        prev_lines = '{scl: 1'b1, sda: 1'b1};
  logic [TIME_W-1:0] high_run = '0;
  logic [DATA_W-1:0] tx_byte_q = '0;   // SDA at each SCL rise
  logic [DATA_W-1:0] rx_byte_q = '0;   // rx_data_o at rx_valid_o
  logic              check_high = 1'b0;
  logic [TIME_W-1:0] exp_high = '0;
  logic              model_on = 1'b0;
  logic [DATA_W-1:0] model_byte = '0;
  logic [TIME_W-1:0] model_base = '0;
  int                seed = 32'hfa45;
  int                cycles = 0;
  int                cycle_limit = 0;
  int                pp_mhz [3] = '{100, 200, 400};
  int                pp_half [3][5] = '{'{4, 7, 9, 13, 25},
                                        '{8, 13, 17, 25, 50},
                                        '{16, 25, 34, 50, 100}};

  i3c_ctrl_top u_i3c_ctrl_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .enable_i     (enable),
    .od_pp_mode_i (od_pp_mode),
    .od_timing_i  (od_timing),
    .pp_cfg_i     (pp_cfg),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd_req),
    .sda_i        (sda),
    .lines_o      (lines),
    .idle_o       (idle),
    .cmd_done_o   (cmd_done),
    .rx_valid_o   (rx_valid),
    .rx_data_o    (rx_data)
  );

  always #2 clk = ~clk;  // 250 MHz

  // ==============================
  // Checks
  // ==============================
  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_lines(input string name, input bus_lines_t got, input bus_lines_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_time(input string name, input logic [TIME_W-1:0] got,
                            input logic [TIME_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // ==============================
  // Expected timing
  // ==============================
  function automatic int phase_len(input test_entry_t e, input phase_e ph);
    int len;
    if (e.pp) begin
      len = (ph == ph_clock_low || ph == ph_clock_pulse) ? int'(e.exp_high) : 1;
    end else begin
      case (ph)
        ph_setup_start: len = int'(e.od.t_r) + int'(e.od.tsu_sta);
        ph_hold_start:  len = int'(e.od.t_f) + int'(e.od.thd_sta);
        ph_clock_low:   len = int'(e.od.tlow) - int'(e.od.thd_dat);
        ph_clock_pulse: len = int'(e.od.t_r) + int'(e.od.thigh);
        ph_hold_bit:    len = int'(e.od.t_f) + int'(e.od.thd_dat);
        ph_setup_stop:  len = int'(e.od.t_r) + int'(e.od.tsu_sto);
        ph_hold_stop:   len = int'(e.od.t_r) + int'(e.od.t_buf) - int'(e.od.tsu_sta);
        default:        len = 1;
      endcase
    end
    if (len < 1) len = 1;  // Clamp
    return len;
  endfunction

  // Cycles from acceptance to the last cycle of the final phase
  function automatic int cmd_len(input test_entry_t e);
    int len;
    case (e.cmd)
      cmd_start: len = phase_len(e, ph_setup_start) + phase_len(e, ph_hold_start) + 1;
      cmd_stop:  len = phase_len(e, ph_setup_stop) + phase_len(e, ph_hold_stop);
      default:   len = int'(DATA_W) * (phase_len(e, ph_clock_low) +
                       phase_len(e, ph_clock_pulse) + phase_len(e, ph_hold_bit));
    endcase
    return e.en ? len : 0;
  endfunction

  function automatic int run_budget();
    int total;
    total = 64;                                  // Reset plus margin
    foreach (tests[i]) total += cmd_len(tests[i]) + 16;
    return total;
  endfunction

  function automatic counts_t count_delta(input counts_t now, input counts_t base);
    counts_t d;
    d.busy    = now.busy - base.busy;
    d.done    = now.done - base.done;
    d.rx      = now.rx - base.rx;
    d.start   = now.start - base.start;
    d.stop    = now.stop - base.stop;
    d.rise    = now.rise - base.rise;
    d.sda_low = now.sda_low - base.sda_low;
    return d;
  endfunction

  // ==============================
  // Bus monitor and target
  // ==============================
  always @(negedge clk) begin : monitor
    if (rst_n) begin
      if (!idle) cnt.busy = cnt.busy + 1'b1;
      if (cmd_done) cnt.done = cnt.done + 1'b1;
      if (!lines.sda) cnt.sda_low = cnt.sda_low + 1'b1;
      if (rx_valid) begin
        cnt.rx    = cnt.rx + 1'b1;
        rx_byte_q = rx_data;
      end
      if (lines.scl && !prev_lines.scl && !idle) begin
        cnt.rise  = cnt.rise + 1'b1;
        tx_byte_q = {tx_byte_q[DATA_W-2:0], lines.sda};  // MSB first
      end
      if (lines.scl && prev_lines.scl) begin
        if (prev_lines.sda && !lines.sda) cnt.start = cnt.start + 1'b1;
        if (!prev_lines.sda && lines.sda) cnt.stop = cnt.stop + 1'b1;
      end
      // Each clock pulse measured at its falling edge
      if (!lines.scl && prev_lines.scl && high_run != '0 && check_high) begin
        check_time("scl high cycles", high_run, exp_high);
      end
      high_run = (lines.scl && !idle) ? high_run + 1'b1 : '0;
    end
    prev_lines = lines;
  end

  always @(posedge clk) begin : target_model
    logic [TIME_W-1:0]    seen;
    logic [BIT_IDX_W-1:0] bit_pos;
    #1;
    seen    = cnt.rise - model_base;
    bit_pos = BIT_IDX_W'(DATA_W - 1) - seen[BIT_IDX_W-1:0];
    if (!model_on) begin
      sda = 1'b1;                   // Released
    end else if (!lines.scl && seen < TIME_W'(DATA_W)) begin
      sda = model_byte[bit_pos];    // Only while SCL low
    end
  end

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, a command never finished", cycles);
      abort_run();
    end
  end

  // ==============================
  // Table and sequencing
  // ==============================
  task automatic add_test(input logic pp, input logic en, input logic poke,
                          input od_timing_t od, input pp_cfg_t ppc, input bus_cmd_e cmd,
                          input logic [DATA_W-1:0] data, input logic [TIME_W-1:0] high);
    test_entry_t e;
    e = '{pp: pp, en: en, poke: poke, od: od, ppc: ppc, cmd: cmd,
          data: data, exp_high: high};
    tests.push_back(e);
  endtask

  task automatic fill_table();
    od_timing_t od_a;
    od_timing_t od_b;
    pp_cfg_t    ppc;
    od_a = '{t_r: 20'd2, t_f: 20'd1, thigh: 20'd5, tlow: 20'd6, thd_sta: 20'd4,
             tsu_sta: 20'd3, tsu_sto: 20'd4, tsu_dat: 20'd2, thd_dat: 20'd1, t_buf: 20'd6};
    // Short tlow and t_buf, both clamp to one cycle
    od_b = '{t_r: 20'd1, t_f: 20'd1, thigh: 20'd3, tlow: 20'd1, thd_sta: 20'd2,
             tsu_sta: 20'd5, tsu_sto: 20'd2, tsu_dat: 20'd1, thd_dat: 20'd2, t_buf: 20'd1};
    ppc  = '{sys_clk_mhz: 16'd100, sdr: sdr0};
    add_test(1'b0, 1'b1, 1'b0, od_a, ppc, cmd_start, 8'h00, 20'd7);
    add_test(1'b0, 1'b1, 1'b1, od_a, ppc, cmd_tx, 8'ha5, 20'd7);     // Poked while busy
    add_test(1'b0, 1'b1, 1'b0, od_a, ppc, cmd_rx, 8'h3c, 20'd7);
    add_test(1'b0, 1'b1, 1'b0, od_b, ppc, cmd_tx, 8'h96, 20'd4);
    add_test(1'b0, 1'b1, 1'b0, od_a, ppc, cmd_stop, 8'h00, 20'd7);
    add_test(1'b0, 1'b1, 1'b0, od_b, ppc, cmd_stop, 8'h00, 20'd4);
    add_test(1'b0, 1'b0, 1'b0, od_a, ppc, cmd_start, 8'h00, 20'd7);  // Gate closed
    for (int f = 0; f < 3; f++) begin
      for (int s = 0; s < 5; s++) begin
        ppc = '{sys_clk_mhz: 16'(pp_mhz[f]), sdr: sdr_mode_e'(s)};
        add_test(1'b1, 1'b1, 1'b0, od_a, ppc, (s % 2 == 1) ? cmd_rx : cmd_tx,
                 DATA_W'($random(seed)), TIME_W'(pp_half[f][s]));
      end
    end
    ppc = '{sys_clk_mhz: 16'd150, sdr: sdr2};                        // Falls back to 100 MHz
    add_test(1'b1, 1'b1, 1'b0, od_a, ppc, cmd_tx, 8'h5a, 20'd9);
    add_test(1'b1, 1'b1, 1'b0, od_a, ppc, cmd_start, 8'h00, 20'd9);
    add_test(1'b1, 1'b1, 1'b0, od_a, ppc, cmd_stop, 8'h00, 20'd9);
  endtask

  // Called and returns just after a rising edge
  task automatic issue_cmd(input bus_cmd_e cmd, input logic [DATA_W-1:0] data);
    cmd_valid = 1'b1;
    cmd_req   = '{cmd: cmd, data: data};
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic run_entry(input test_entry_t e);
    counts_t base;
    counts_t delta;
    logic    is_byte;
    is_byte    = (e.cmd == cmd_tx || e.cmd == cmd_rx);
    od_pp_mode = e.pp;
    od_timing  = e.od;
    pp_cfg     = e.ppc;
    enable     = e.en;
    check_high = is_byte;
    exp_high   = e.exp_high;
    model_on   = (e.cmd == cmd_rx);
    model_byte = e.data;
    model_base = cnt.rise;
    @(posedge clk);
    #1;
    base = cnt;
    issue_cmd(e.cmd, e.data);
    if (!e.en) begin
      repeat (8) begin
        @(posedge clk);
        #1;
        check_flag("idle_o", idle, 1'b1);
      end
    end else begin
      if (e.poke) begin
        @(posedge clk);
        #1;
        issue_cmd(cmd_start, ~e.data);  // Must be dropped
      end
      do @(negedge clk); while (!cmd_done);
      // Late or repeated strobes still land in the counts
      repeat (3) begin
        @(posedge clk);
        #1;
        check_flag("idle_o", idle, 1'b1);
      end
    end
    delta = count_delta(cnt, base);
    check_lines("lines_o", lines, '{scl: 1'b1, sda: 1'b1});
    check_time("busy cycles", delta.busy, TIME_W'(cmd_len(e)));
    check_time("cmd_done_o pulses", delta.done, TIME_W'(e.en));
    if (e.en && e.cmd == cmd_start) check_time("start conditions", delta.start, TIME_W'(1));
    if (e.en && e.cmd == cmd_stop) check_time("stop conditions", delta.stop, TIME_W'(1));
    if (e.en && is_byte) check_time("scl rises", delta.rise, TIME_W'(DATA_W));
    if (e.en && e.cmd == cmd_tx) check_byte("sda at scl rise", tx_byte_q, e.data);
    if (e.en && e.cmd == cmd_rx) begin
      check_time("rx_valid_o pulses", delta.rx, TIME_W'(1));
      check_byte("rx_data_o", rx_byte_q, e.data);
      check_time("sda low cycles", delta.sda_low, '0);  // Released for RX
    end
  endtask

  initial begin : main
    rst_n      = 1'b0;
    enable     = 1'b1;
    od_pp_mode = 1'b0;
    od_timing  = '0;
    pp_cfg     = '{sys_clk_mhz: 16'd100, sdr: sdr0};
    cmd_valid  = 1'b0;
    cmd_req    = '0;
    fill_table();
    cycle_limit = run_budget();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_lines("lines_o", lines, '{scl: 1'b1, sda: 1'b1});  // Released after reset
    check_flag("idle_o", idle, 1'b1);
    check_flag("cmd_done_o", cmd_done, 1'b0);
    check_flag("rx_valid_o", rx_valid, 1'b0);
    foreach (tests[i]) run_entry(tests[i]);
    $display("Finished with no errors");
    $finish;
  end

endmodule
